/* hdl/dispatch_consts.svh */
// dispatch and issue slice sizes
// shared by the package and every RTL block of the slice

`ifndef DISPATCH_CONSTS_SVH
`define DISPATCH_CONSTS_SVH

// physical register file
`define PRF_ENTRIES   32
`define PRF_INDEX_W   5

// micro-op identity width, wide enough for tracing order
`define UOP_TAG_W     6

// input buffer depth, also the upstream credit count
// power of two so the pointers wrap on their own
`define IN_DEPTH      4

// entries per issue queue
`define IQ_DEPTH      4

// outstanding micro-ops allowed per execution unit
`define EXEC_CREDITS  2

`endif

/* hdl/dispatch_pkg.sv */
// dispatch and issue types
// unit class, register index, tag and the micro-op carried between blocks

`include "dispatch_consts.svh"

package dispatch_pkg;

  // execution unit class a micro-op is steered to
  typedef enum logic {
    UNIT_INT = 1'b0,
    UNIT_MEM = 1'b1
  } unit_t;

  typedef logic [`PRF_INDEX_W-1:0] prf_index_t;

  typedef logic [`UOP_TAG_W-1:0] uop_tag_t;

  // renamed micro-op, only what dispatch and issue look at
  typedef struct packed {
    uop_tag_t   tag;
    unit_t      unit;
    prf_index_t rd;
    logic       rd_valid;
    prf_index_t rs1;
    logic       rs1_valid;
    prf_index_t rs2;
    logic       rs2_valid;
  } uop_t;

endpackage

/* hdl/uop_in_buffer.sv */
// input buffer for decoded micro-ops
// circular FIFO filled under upstream credits, one credit back per pop

`timescale 1ns/1ps

`include "dispatch_consts.svh"

module uop_in_buffer (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    flush,
  input  logic                    in_valid,
  input  dispatch_pkg::uop_tag_t  in_tag,
  input  dispatch_pkg::unit_t     in_unit,
  input  dispatch_pkg::prf_index_t in_rd,
  input  logic                    in_rd_valid,
  input  dispatch_pkg::prf_index_t in_rs1,
  input  logic                    in_rs1_valid,
  input  dispatch_pkg::prf_index_t in_rs2,
  input  logic                    in_rs2_valid,
  input  logic                    head_pop,
  output dispatch_pkg::uop_t      head_uop,
  output logic                    head_valid,
  output logic                    in_credit
);

  import dispatch_pkg::*;

  localparam int PTR_W = $clog2(`IN_DEPTH);
  localparam int CNT_W = $clog2(`IN_DEPTH + 1);

  uop_t             fifo_mem [`IN_DEPTH];
  uop_t             in_uop;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             pop;

  // gather the loose upstream fields into one micro-op
  assign in_uop = '{tag: in_tag, unit: in_unit, rd: in_rd, rd_valid: in_rd_valid,
                    rs1: in_rs1, rs1_valid: in_rs1_valid,
                    rs2: in_rs2, rs2_valid: in_rs2_valid};

  assign head_valid = (count != '0);
  assign head_uop   = fifo_mem[rd_ptr];
  assign pop        = head_pop && head_valid;

  // storage, upstream credits guarantee a free slot
  always_ff @(posedge clock) begin
    if (in_valid) begin
      fifo_mem[wr_ptr] <= in_uop;
    end
  end

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      in_credit <= 1'b0;
    end else begin
      if (in_valid) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      count     <= count + CNT_W'(in_valid) - CNT_W'(pop);
      // credit goes back one cycle after the entry leaves
      in_credit <= pop;
    end
  end

endmodule

/* hdl/dispatch_steer.sv */
// dispatch steering
// sends the buffer head to the int or mem issue queue and marks its rd busy

`timescale 1ns/1ps

module dispatch_steer (
  input  dispatch_pkg::uop_t       head_uop,
  input  logic                     head_valid,
  input  logic                     int_full,
  input  logic                     mem_full,
  output logic                     head_pop,
  output logic                     int_write,
  output logic                     mem_write,
  output logic                     set_valid,
  output dispatch_pkg::prf_index_t set_index,
  output dispatch_pkg::uop_t       dispatch_uop
);

  import dispatch_pkg::*;

  logic to_mem;
  logic target_full;

  // unit class picks the queue
  assign to_mem = (head_uop.unit == UNIT_MEM);

  // only the target queue's room matters
  assign target_full = to_mem ? mem_full : int_full;

  // head leaves when its queue has room, else it stays put
  assign head_pop = head_valid && !target_full;

  // one write per cycle at most
  assign int_write = head_pop && !to_mem;
  assign mem_write = head_pop && to_mem;

  // same micro-op goes to either queue
  assign dispatch_uop = head_uop;

  // destination goes busy at the dispatch edge
  // no rd, nothing to mark
  assign set_valid = head_pop && head_uop.rd_valid;
  assign set_index = head_uop.rd;

endmodule

/* hdl/busy_scoreboard.sv */
// physical register busy scoreboard
// set at dispatch, cleared at writeback, looked up by every queue entry

`timescale 1ns/1ps

`include "dispatch_consts.svh"

module busy_scoreboard (
  input  logic                                      clock,
  input  logic                                      reset,
  input  logic                                      flush,
  input  logic                                      set_valid,
  input  dispatch_pkg::prf_index_t                  set_index,
  input  logic                                      wb_valid,
  input  dispatch_pkg::prf_index_t                  wb_index,
  input  dispatch_pkg::prf_index_t [`IQ_DEPTH-1:0]  int_rs1_index,
  input  dispatch_pkg::prf_index_t [`IQ_DEPTH-1:0]  int_rs2_index,
  input  dispatch_pkg::prf_index_t [`IQ_DEPTH-1:0]  mem_rs1_index,
  input  dispatch_pkg::prf_index_t [`IQ_DEPTH-1:0]  mem_rs2_index,
  output logic [`IQ_DEPTH-1:0]                      int_rs1_busy,
  output logic [`IQ_DEPTH-1:0]                      int_rs2_busy,
  output logic [`IQ_DEPTH-1:0]                      mem_rs1_busy,
  output logic [`IQ_DEPTH-1:0]                      mem_rs2_busy
);

  import dispatch_pkg::*;

  logic [`PRF_ENTRIES-1:0] busy;

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      busy <= '0;
    end else begin
      if (wb_valid) busy[wb_index] <= 1'b0;
      // set comes last so it wins on the same index
      if (set_valid) busy[set_index] <= 1'b1;
    end
  end

  // lookups see only the registered vector, updates show a cycle later
  always_comb begin
    for (int i = 0; i < `IQ_DEPTH; i++) begin
      int_rs1_busy[i] = busy[int_rs1_index[i]];
      int_rs2_busy[i] = busy[int_rs2_index[i]];
      mem_rs1_busy[i] = busy[mem_rs1_index[i]];
      mem_rs2_busy[i] = busy[mem_rs2_index[i]];
    end
  end

endmodule

/* hdl/issue_queue.sv */
// age-ordered issue queue
// slot 0 is oldest, entries compact down after an issue
// issues the oldest entry whose sources are ready, if the port has a credit

`timescale 1ns/1ps

`include "dispatch_consts.svh"

module issue_queue (
  input  logic                                      clock,
  input  logic                                      reset,
  input  logic                                      flush,
  input  logic                                      write,
  input  dispatch_pkg::uop_t                        write_uop,
  output logic                                      full,
  output dispatch_pkg::prf_index_t [`IQ_DEPTH-1:0]  rs1_index,
  output dispatch_pkg::prf_index_t [`IQ_DEPTH-1:0]  rs2_index,
  input  logic [`IQ_DEPTH-1:0]                      rs1_busy,
  input  logic [`IQ_DEPTH-1:0]                      rs2_busy,
  input  logic                                      credit_avail,
  output logic                                      issue_fire,
  output dispatch_pkg::uop_t                        issue_uop
);

  import dispatch_pkg::*;

  localparam int SEL_W = $clog2(`IQ_DEPTH);

  uop_t                 entry_q [`IQ_DEPTH];
  logic [`IQ_DEPTH-1:0] entry_valid;
  uop_t                 next_q [`IQ_DEPTH];
  logic [`IQ_DEPTH-1:0] next_valid;
  logic [`IQ_DEPTH-1:0] ready;
  logic [SEL_W-1:0]     sel;

  // valid entries are contiguous from slot 0
  assign full = &entry_valid;

  // source indices out to the scoreboard
  always_comb begin
    for (int i = 0; i < `IQ_DEPTH; i++) begin
      rs1_index[i] = entry_q[i].rs1;
      rs2_index[i] = entry_q[i].rs2;
    end
  end

  // ready when every valid source is no longer busy
  always_comb begin
    for (int i = 0; i < `IQ_DEPTH; i++) begin
      ready[i] = entry_valid[i]
              && (!entry_q[i].rs1_valid || !rs1_busy[i])
              && (!entry_q[i].rs2_valid || !rs2_busy[i]);
    end
  end

  // lowest ready slot, scanned top down so the oldest wins
  // a younger ready entry can pass a stalled older one
  always_comb begin
    sel = '0;
    for (int i = `IQ_DEPTH - 1; i >= 0; i--) begin
      if (ready[i]) sel = SEL_W'(i);
    end
  end

  // no credit holds everything in place
  assign issue_fire = credit_avail && (|ready);
  assign issue_uop  = entry_q[sel];

  // remove the issued slot first, then append the new one
  always_comb begin
    logic placed;
    placed     = 1'b0;
    next_q     = entry_q;
    next_valid = entry_valid;
    if (issue_fire) begin
      for (int i = 0; i < `IQ_DEPTH - 1; i++) begin
        if (i >= int'(sel)) begin
          next_q[i]     = entry_q[i + 1];
          next_valid[i] = entry_valid[i + 1];
        end
      end
      // top slot always frees up after a removal
      next_valid[`IQ_DEPTH-1] = 1'b0;
    end
    if (write) begin
      for (int i = 0; i < `IQ_DEPTH; i++) begin
        if (!placed && !next_valid[i]) begin
          next_q[i]     = write_uop;
          next_valid[i] = 1'b1;
          placed        = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    entry_q <= next_q;
  end

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      entry_valid <= '0;
    end else begin
      entry_valid <= next_valid;
    end
  end

endmodule

/* hdl/issue_port.sv */
// issue port towards one execution unit
// credit counter plus the registered issue outputs

`timescale 1ns/1ps

`include "dispatch_consts.svh"

module issue_port (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     issue_fire,
  input  dispatch_pkg::uop_t       issue_uop,
  input  logic                     credit_return,
  output logic                     credit_avail,
  output logic                     issue_valid,
  output dispatch_pkg::uop_tag_t   issue_tag,
  output dispatch_pkg::prf_index_t issue_rd,
  output logic                     issue_rd_valid
);

  import dispatch_pkg::*;

  localparam int CRED_W = $clog2(`EXEC_CREDITS + 1);

  logic [CRED_W-1:0] credits;
  uop_t              issue_q;

  assign credit_avail = (credits != '0);

  // spend on issue, refill on return, both at once cancel out
  // flush does not touch this, the unit still owns its work
  always_ff @(posedge clock) begin
    if (reset) begin
      credits <= CRED_W'(`EXEC_CREDITS);
    end else begin
      case ({issue_fire, credit_return})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  // one-cycle valid per issued micro-op
  always_ff @(posedge clock) begin
    if (reset) begin
      issue_valid <= 1'b0;
    end else begin
      issue_valid <= issue_fire;
    end
  end

  always_ff @(posedge clock) begin
    if (issue_fire) issue_q <= issue_uop;
  end

  // unit only needs identity and destination
  assign issue_tag      = issue_q.tag;
  assign issue_rd       = issue_q.rd;
  assign issue_rd_valid = issue_q.rd_valid;

endmodule

/* hdl/dispatch_issue.sv */
// dispatch and issue slice top
// input buffer, steering, scoreboard, int and mem queues with their ports

`timescale 1ns/1ps

`include "dispatch_consts.svh"

module dispatch_issue (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     flush,
  input  logic                     in_valid,
  input  dispatch_pkg::uop_tag_t   in_tag,
  input  dispatch_pkg::unit_t      in_unit,
  input  dispatch_pkg::prf_index_t in_rd,
  input  logic                     in_rd_valid,
  input  dispatch_pkg::prf_index_t in_rs1,
  input  logic                     in_rs1_valid,
  input  dispatch_pkg::prf_index_t in_rs2,
  input  logic                     in_rs2_valid,
  output logic                     in_credit,
  input  logic                     wb_valid,
  input  dispatch_pkg::prf_index_t wb_index,
  input  logic                     int_credit,
  input  logic                     mem_credit,
  output logic                     int_issue_valid,
  output dispatch_pkg::uop_tag_t   int_issue_tag,
  output dispatch_pkg::prf_index_t int_issue_rd,
  output logic                     int_issue_rd_valid,
  output logic                     mem_issue_valid,
  output dispatch_pkg::uop_tag_t   mem_issue_tag,
  output dispatch_pkg::prf_index_t mem_issue_rd,
  output logic                     mem_issue_rd_valid
);

  import dispatch_pkg::*;

  // buffer head and steering
  uop_t       head_uop;
  logic       head_valid;
  logic       head_pop;
  uop_t       dispatch_uop;
  logic       int_write;
  logic       mem_write;
  logic       set_valid;
  prf_index_t set_index;

  // queue state and scoreboard lookups
  logic                         int_full;
  logic                         mem_full;
  prf_index_t [`IQ_DEPTH-1:0]   int_rs1_index;
  prf_index_t [`IQ_DEPTH-1:0]   int_rs2_index;
  prf_index_t [`IQ_DEPTH-1:0]   mem_rs1_index;
  prf_index_t [`IQ_DEPTH-1:0]   mem_rs2_index;
  logic [`IQ_DEPTH-1:0]         int_rs1_busy;
  logic [`IQ_DEPTH-1:0]         int_rs2_busy;
  logic [`IQ_DEPTH-1:0]         mem_rs1_busy;
  logic [`IQ_DEPTH-1:0]         mem_rs2_busy;

  // queue to port
  logic int_credit_avail;
  logic mem_credit_avail;
  logic int_issue_fire;
  logic mem_issue_fire;
  uop_t int_issue_uop;
  uop_t mem_issue_uop;

  uop_in_buffer in_buffer (
    .clock        (clock),
    .reset        (reset),
    .flush        (flush),
    .in_valid     (in_valid),
    .in_tag       (in_tag),
    .in_unit      (in_unit),
    .in_rd        (in_rd),
    .in_rd_valid  (in_rd_valid),
    .in_rs1       (in_rs1),
    .in_rs1_valid (in_rs1_valid),
    .in_rs2       (in_rs2),
    .in_rs2_valid (in_rs2_valid),
    .head_pop     (head_pop),
    .head_uop     (head_uop),
    .head_valid   (head_valid),
    .in_credit    (in_credit)
  );

  dispatch_steer steer (
    .head_uop     (head_uop),
    .head_valid   (head_valid),
    .int_full     (int_full),
    .mem_full     (mem_full),
    .head_pop     (head_pop),
    .int_write    (int_write),
    .mem_write    (mem_write),
    .set_valid    (set_valid),
    .set_index    (set_index),
    .dispatch_uop (dispatch_uop)
  );

  busy_scoreboard scoreboard (
    .clock         (clock),
    .reset         (reset),
    .flush         (flush),
    .set_valid     (set_valid),
    .set_index     (set_index),
    .wb_valid      (wb_valid),
    .wb_index      (wb_index),
    .int_rs1_index (int_rs1_index),
    .int_rs2_index (int_rs2_index),
    .mem_rs1_index (mem_rs1_index),
    .mem_rs2_index (mem_rs2_index),
    .int_rs1_busy  (int_rs1_busy),
    .int_rs2_busy  (int_rs2_busy),
    .mem_rs1_busy  (mem_rs1_busy),
    .mem_rs2_busy  (mem_rs2_busy)
  );

  issue_queue int_queue (
    .clock        (clock),
    .reset        (reset),
    .flush        (flush),
    .write        (int_write),
    .write_uop    (dispatch_uop),
    .full         (int_full),
    .rs1_index    (int_rs1_index),
    .rs2_index    (int_rs2_index),
    .rs1_busy     (int_rs1_busy),
    .rs2_busy     (int_rs2_busy),
    .credit_avail (int_credit_avail),
    .issue_fire   (int_issue_fire),
    .issue_uop    (int_issue_uop)
  );

  issue_queue mem_queue (
    .clock        (clock),
    .reset        (reset),
    .flush        (flush),
    .write        (mem_write),
    .write_uop    (dispatch_uop),
    .full         (mem_full),
    .rs1_index    (mem_rs1_index),
    .rs2_index    (mem_rs2_index),
    .rs1_busy     (mem_rs1_busy),
    .rs2_busy     (mem_rs2_busy),
    .credit_avail (mem_credit_avail),
    .issue_fire   (mem_issue_fire),
    .issue_uop    (mem_issue_uop)
  );

  issue_port int_port (
    .clock          (clock),
    .reset          (reset),
    .issue_fire     (int_issue_fire),
    .issue_uop      (int_issue_uop),
    .credit_return  (int_credit),
    .credit_avail   (int_credit_avail),
    .issue_valid    (int_issue_valid),
    .issue_tag      (int_issue_tag),
    .issue_rd       (int_issue_rd),
    .issue_rd_valid (int_issue_rd_valid)
  );

  issue_port mem_port (
    .clock          (clock),
    .reset          (reset),
    .issue_fire     (mem_issue_fire),
    .issue_uop      (mem_issue_uop),
    .credit_return  (mem_credit),
    .credit_avail   (mem_credit_avail),
    .issue_valid    (mem_issue_valid),
    .issue_tag      (mem_issue_tag),
    .issue_rd       (mem_issue_rd),
    .issue_rd_valid (mem_issue_rd_valid)
  );

endmodule

/* test/dispatch_issue_asserts.sv */
// protocol checks on the dispatch and issue slice boundary
// credit and issue valid rules, bound onto the top level

`timescale 1ns/1ps

`include "dispatch_consts.svh"

module dispatch_issue_asserts (
  input logic                   clock,
  input logic                   reset,
  input logic                   in_credit,
  input logic                   int_issue_valid,
  input dispatch_pkg::uop_tag_t int_issue_tag,
  input logic                   mem_issue_valid,
  input dispatch_pkg::uop_tag_t mem_issue_tag,
  input logic                   int_credit,
  input logic                   mem_credit
);

  localparam int CRED_W = $clog2(`EXEC_CREDITS + 1);

  logic [CRED_W-1:0] int_shadow;
  logic [CRED_W-1:0] mem_shadow;

  // credits as seen from outside, one cycle behind the port
  always_ff @(posedge clock) begin
    if (reset) begin
      int_shadow <= CRED_W'(`EXEC_CREDITS);
      mem_shadow <= CRED_W'(`EXEC_CREDITS);
    end else begin
      int_shadow <= int_shadow - CRED_W'(int_issue_valid) + CRED_W'(int_credit);
      mem_shadow <= mem_shadow - CRED_W'(mem_issue_valid) + CRED_W'(mem_credit);
    end
  end

  quiet_in_reset: assert property (@(posedge clock)
    reset |=> !in_credit && !int_issue_valid && !mem_issue_valid)
    else $error("credit or issue valid active during reset");

  // a valid held high must be a new micro-op each cycle
  int_single_pulse: assert property (@(posedge clock) disable iff (reset)
    int_issue_valid && $past(int_issue_valid) |-> int_issue_tag != $past(int_issue_tag))
    else $error("int issue valid held for one micro-op");

  mem_single_pulse: assert property (@(posedge clock) disable iff (reset)
    mem_issue_valid && $past(mem_issue_valid) |-> mem_issue_tag != $past(mem_issue_tag))
    else $error("mem issue valid held for one micro-op");

  int_has_credit: assert property (@(posedge clock) disable iff (reset)
    int_issue_valid |-> int_shadow != '0)
    else $error("int port issued without a credit");

  mem_has_credit: assert property (@(posedge clock) disable iff (reset)
    mem_issue_valid |-> mem_shadow != '0)
    else $error("mem port issued without a credit");

endmodule

/* test/tb_dispatch_issue.sv */
// testbench for the dispatch and issue slice
// table-driven upstream, execution unit and writeback models with self checks

`timescale 1ns/1ps

`include "dispatch_consts.svh"

module tb_dispatch_issue;

  import dispatch_pkg::*;

  localparam int MAX_ENTRIES = 32;

  // tag of a table row is its row number plus one
  typedef struct packed {
    logic [2:0] test;
    logic       flush_before;
    unit_t      unit;
    prf_index_t rd;
    logic       rd_valid;
    prf_index_t rs1;
    logic       rs1_valid;
    prf_index_t rs2;
    logic       rs2_valid;
    uop_tag_t   after_tag;
  } entry_t;

  logic       clock;
  logic       reset;
  logic       flush;
  logic       in_valid;
  uop_tag_t   in_tag;
  unit_t      in_unit;
  prf_index_t in_rd;
  logic       in_rd_valid;
  prf_index_t in_rs1;
  logic       in_rs1_valid;
  prf_index_t in_rs2;
  logic       in_rs2_valid;
  logic       in_credit;
  logic       wb_valid;
  prf_index_t wb_index;
  logic       int_credit;
  logic       mem_credit;
  logic       int_issue_valid;
  uop_tag_t   int_issue_tag;
  prf_index_t int_issue_rd;
  logic       int_issue_rd_valid;
  logic       mem_issue_valid;
  uop_tag_t   mem_issue_tag;
  prf_index_t mem_issue_rd;
  logic       mem_issue_rd_valid;

  entry_t stim [$];
  bit     sent [MAX_ENTRIES];
  bit     issued [MAX_ENTRIES];
  bit     flushed [MAX_ENTRIES];
  int     wb_tick [MAX_ENTRIES];
  int     producer [MAX_ENTRIES];
  int     last_indep [2];
  // execution unit model returns in issue order
  int     pending_idx [$];
  int     pending_due [$];
  int     up_credits;
  int     cycles;
  int     cycle_limit;
  int     checks;
  int     errors;
  bit     hold;
  logic [7:0] lfsr;

  dispatch_issue dispatch_issue_i (.*);

  bind dispatch_issue dispatch_issue_asserts protocol_checks (
    .clock           (clock),
    .reset           (reset),
    .in_credit       (in_credit),
    .int_issue_valid (int_issue_valid),
    .int_issue_tag   (int_issue_tag),
    .mem_issue_valid (mem_issue_valid),
    .mem_issue_tag   (mem_issue_tag),
    .int_credit      (int_credit),
    .mem_credit      (mem_credit)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // stops a run that never reaches its end
  initial begin
    wait (cycle_limit > 0);
    while (cycles <= cycle_limit) @(posedge clock);
    $display("timeout: run did not finish within %0d cycles", cycle_limit);
    $display("TEST FAIL");
    $finish;
  end

  function automatic void add_entry(int test, int fl, unit_t unit, int rd, int rdv,
                                    int rs1, int rs1v, int rs2, int rs2v, int after);
    entry_t e;
    e.test         = 3'(test);
    e.flush_before = (fl != 0);
    e.unit         = unit;
    e.rd           = prf_index_t'(rd);
    e.rd_valid     = (rdv != 0);
    e.rs1          = prf_index_t'(rs1);
    e.rs1_valid    = (rs1v != 0);
    e.rs2          = prf_index_t'(rs2);
    e.rs2_valid    = (rs2v != 0);
    e.after_tag    = uop_tag_t'(after);
    stim.push_back(e);
  endfunction

  // test, flush, unit, rd, rd_valid, rs1, rs1_valid, rs2, rs2_valid, must follow tag
  function automatic void build_table();
    add_entry(1, 0, UNIT_INT,  1, 1,  0, 0, 0, 0, 0);
    add_entry(1, 0, UNIT_MEM,  2, 1,  0, 0, 0, 0, 0);
    add_entry(1, 0, UNIT_INT,  3, 1,  0, 0, 0, 0, 0);
    add_entry(1, 0, UNIT_MEM,  4, 0,  0, 0, 0, 0, 0);
    add_entry(1, 0, UNIT_INT,  5, 1,  0, 0, 0, 0, 0);
    add_entry(2, 0, UNIT_MEM,  6, 1,  1, 1, 0, 0, 0);
    add_entry(2, 0, UNIT_INT,  7, 1,  0, 0, 0, 0, 0);
    add_entry(2, 0, UNIT_MEM,  8, 0,  0, 0, 0, 0, 0);
    add_entry(2, 0, UNIT_INT,  9, 1,  0, 0, 3, 1, 0);
    add_entry(2, 0, UNIT_INT, 10, 1,  0, 0, 0, 0, 0);
    // tag 12 waits on tag 11 and tag 13 passes it
    add_entry(3, 0, UNIT_INT, 11, 1,  0, 0, 0, 0, 0);
    add_entry(3, 0, UNIT_INT, 12, 1, 11, 1, 0, 0, 13);
    add_entry(3, 0, UNIT_INT, 13, 1,  2, 1, 0, 0, 0);
    add_entry(3, 0, UNIT_MEM, 14, 1,  0, 0, 11, 1, 0);
    add_entry(4, 0, UNIT_INT, 15, 1,  0, 0, 0, 0, 0);
    add_entry(4, 0, UNIT_INT, 16, 1,  0, 0, 0, 0, 0);
    add_entry(4, 0, UNIT_INT, 17, 1,  0, 0, 0, 0, 0);
    add_entry(4, 0, UNIT_MEM, 18, 1,  0, 0, 0, 0, 0);
    add_entry(4, 0, UNIT_MEM, 19, 1,  0, 0, 0, 0, 0);
    add_entry(4, 0, UNIT_MEM, 20, 0,  0, 0, 0, 0, 0);
    // 22 and 23 still inside when the flush hits
    add_entry(5, 0, UNIT_INT, 21, 1,  0, 0, 0, 0, 0);
    add_entry(5, 0, UNIT_INT, 22, 1, 21, 1, 0, 0, 0);
    add_entry(5, 0, UNIT_MEM, 23, 1,  0, 0, 0, 0, 0);
    add_entry(5, 1, UNIT_MEM, 24, 1,  0, 0, 0, 0, 0);
    // reg 22 is only free again if flush cleared its busy bit
    add_entry(5, 0, UNIT_INT, 25, 1, 22, 1, 0, 0, 0);
    add_entry(5, 0, UNIT_MEM, 26, 1,  0, 0, 0, 0, 0);
  endfunction

  // nearest older writer of a source within the same test and flush window
  function automatic int producer_of(int j);
    for (int i = j - 1; i >= 0; i--) begin
      if (stim[i].test != stim[j].test || stim[i + 1].flush_before) return -1;
      if (stim[i].rd_valid && ((stim[j].rs1_valid && stim[j].rs1 == stim[i].rd) ||
                               (stim[j].rs2_valid && stim[j].rs2 == stim[i].rd))) return i;
    end
    return -1;
  endfunction

  function automatic string test_title(int t);
    case (t)
      1: return "reset and upstream credits";
      2: return "routing and order per class";
      3: return "dependency wait and pass";
      4: return "execution credits withheld";
      default: return "flush and recovery";
    endcase
  endfunction

  // galois lfsr with taps x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_next(logic [7:0] s);
    return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
  endfunction

  function automatic int take_bits(int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = (v << 1) | int'(lfsr[0]);
    end
    return v;
  endfunction

  function automatic void compare_value(string name, int got, int expected);
    checks++;
    if (got != expected) begin
      errors++;
      $display("[FAIL] t=%0t %s: got %0d, expected %0d", $time, name, got, expected);
    end
  endfunction

  function automatic void compare_bit(string name, logic got, logic expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("[FAIL] t=%0t %s: got %b, expected %b", $time, name, got, expected);
    end
  endfunction

  function automatic void report_error(string msg);
    errors++;
    $display("error at t=%0t: %s", $time, msg);
  endfunction

  function automatic void check_issue(unit_t port, int tag, int rd, int rd_valid);
    string pfx;
    int    idx;
    int    prod;
    pfx = (port == UNIT_MEM) ? "mem" : "int";
    idx = tag - 1;
    checks++;
    if (idx < 0 || idx >= stim.size() || !sent[idx]) begin
      report_error($sformatf("%s port issued tag %0d, which was never sent", pfx, tag));
    end else if (issued[idx]) begin
      report_error($sformatf("tag %0d issued a second time", tag));
    end else if (flushed[idx]) begin
      report_error($sformatf("tag %0d was discarded by flush but still issued", tag));
    end else begin
      issued[idx] = 1'b1;
      prod        = producer[idx];
      if (stim[idx].unit != port)
        report_error($sformatf("tag %0d came out of the %s port", tag, pfx));
      compare_value({pfx, "_issue_rd_valid"}, rd_valid, int'(stim[idx].rd_valid));
      if (stim[idx].rd_valid) compare_value({pfx, "_issue_rd"}, rd, int'(stim[idx].rd));
      // a clear shows up two edges after the writeback is driven
      if (prod >= 0) begin
        if (wb_tick[prod] < 0 || cycles < wb_tick[prod] + 2)
          report_error($sformatf("tag %0d issued before tag %0d wrote back", tag, prod + 1));
      end else begin
        if (idx <= last_indep[int'(port)])
          report_error($sformatf("tag %0d overtook an older independent micro-op", tag));
        last_indep[int'(port)] = idx;
      end
      if (stim[idx].after_tag != 0 && !issued[stim[idx].after_tag - 1])
        report_error($sformatf("tag %0d issued before younger tag %0d", tag,
                               stim[idx].after_tag));
      pending_idx.push_back(idx);
      pending_due.push_back(cycles + 1 + take_bits(3));
    end
  endfunction

  function automatic void sample_outputs();
    if (in_credit) begin
      up_credits++;
      if (up_credits > `IN_DEPTH) report_error("in_credit returned a credit never spent");
    end
    if (int_issue_valid)
      check_issue(UNIT_INT, int'(int_issue_tag), int'(int_issue_rd), int'(int_issue_rd_valid));
    if (mem_issue_valid)
      check_issue(UNIT_MEM, int'(mem_issue_tag), int'(mem_issue_rd), int'(mem_issue_rd_valid));
  endfunction

  // one credit return per cycle with the writeback of its rd
  function automatic void drive_exec();
    int idx;
    int_credit = 1'b0;
    mem_credit = 1'b0;
    wb_valid   = 1'b0;
    if (!hold && pending_idx.size() > 0 && pending_due[0] <= cycles) begin
      idx = pending_idx.pop_front();
      void'(pending_due.pop_front());
      if (stim[idx].unit == UNIT_MEM) mem_credit = 1'b1;
      else int_credit = 1'b1;
      if (stim[idx].rd_valid) begin
        wb_valid = 1'b1;
        wb_index = stim[idx].rd;
      end
      wb_tick[idx] = cycles;
    end
  endfunction

  // on the falling edge sample outputs first and then drive the models
  task automatic tick();
    @(negedge clock);
    cycles++;
    sample_outputs();
    drive_exec();
  endtask

  task automatic send_entry(int idx);
    while (up_credits == 0) tick();
    in_valid     = 1'b1;
    in_tag       = uop_tag_t'(idx + 1);
    in_unit      = stim[idx].unit;
    in_rd        = stim[idx].rd;
    in_rd_valid  = stim[idx].rd_valid;
    in_rs1       = stim[idx].rs1;
    in_rs1_valid = stim[idx].rs1_valid;
    in_rs2       = stim[idx].rs2;
    in_rs2_valid = stim[idx].rs2_valid;
    up_credits--;
    sent[idx]    = 1'b1;
    tick();
    in_valid     = 1'b0;
  endtask

  // issues registered at the flush edge still count
  task automatic flush_slice();
    flush = 1'b1;
    tick();
    flush = 1'b0;
    for (int i = 0; i < stim.size(); i++) begin
      if (sent[i] && !issued[i]) flushed[i] = 1'b1;
    end
    up_credits = `IN_DEPTH;
  endtask

  function automatic bit test_done(int t);
    for (int i = 0; i < stim.size(); i++) begin
      if (stim[i].test == t && !issued[i] && !flushed[i]) return 1'b0;
    end
    return pending_idx.size() == 0;
  endfunction

  task automatic run_test(int t);
    int err_start;
    int n_int;
    int n_mem;
    int n_flushed;
    bit has_flush;
    err_start = errors;
    n_int     = 0;
    n_mem     = 0;
    n_flushed = 0;
    has_flush = 1'b0;
    hold      = (t == 4);
    for (int i = 0; i < stim.size(); i++) begin
      if (stim[i].test == t) begin
        if (stim[i].flush_before) begin
          has_flush = 1'b1;
          flush_slice();
        end
        send_entry(i);
      end
    end
    if (t == 4) begin
      repeat (20) tick();
      for (int i = 0; i < stim.size(); i++) begin
        if (stim[i].test == t && issued[i] && stim[i].unit == UNIT_INT) n_int++;
        if (stim[i].test == t && issued[i] && stim[i].unit == UNIT_MEM) n_mem++;
      end
      if (n_int > `EXEC_CREDITS || n_mem > `EXEC_CREDITS)
        report_error($sformatf("%0d int and %0d mem issued with no credit back", n_int, n_mem));
      hold = 1'b0;
    end
    while (!test_done(t)) tick();
    for (int i = 0; i < stim.size(); i++) begin
      if (stim[i].test == t && flushed[i]) n_flushed++;
    end
    if (has_flush && n_flushed == 0) report_error("flush discarded no micro-op");
    compare_value("upstream credits", up_credits, `IN_DEPTH);
    $display("test %0d %s: %0d errors", t, test_title(t), errors - err_start);
  endtask

  initial begin
    reset        = 1'b1;
    flush        = 1'b0;
    in_valid     = 1'b0;
    in_tag       = '0;
    in_unit      = UNIT_INT;
    in_rd        = '0;
    in_rd_valid  = 1'b0;
    in_rs1       = '0;
    in_rs1_valid = 1'b0;
    in_rs2       = '0;
    in_rs2_valid = 1'b0;
    wb_valid     = 1'b0;
    wb_index     = '0;
    int_credit   = 1'b0;
    mem_credit   = 1'b0;
    lfsr         = 8'd24;
    up_credits   = `IN_DEPTH;
    cycles       = 0;
    checks       = 0;
    errors       = 0;
    hold         = 1'b0;
    last_indep   = '{-1, -1};
    build_table();
    cycle_limit  = stim.size() * 20;
    for (int i = 0; i < stim.size(); i++) begin
      wb_tick[i]  = -1;
      producer[i] = producer_of(i);
    end
    repeat (5) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    compare_bit("in_credit", in_credit, 1'b0);
    compare_bit("int_issue_valid", int_issue_valid, 1'b0);
    compare_bit("mem_issue_valid", mem_issue_valid, 1'b0);
    for (int t = 1; t <= 5; t++) run_test(t);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* sim.f */
+incdir+hdl
hdl/dispatch_pkg.sv
hdl/uop_in_buffer.sv
hdl/dispatch_steer.sv
hdl/busy_scoreboard.sv
hdl/issue_queue.sv
hdl/issue_port.sv
hdl/dispatch_issue.sv
test/dispatch_issue_asserts.sv
test/tb_dispatch_issue.sv

/* run_sim.sh */
#!/bin/sh
# build the dispatch and issue testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f sim.f \
  --top-module tb_dispatch_issue -Mdir obj_dir -o sim_dispatch_issue &&
./obj_dir/sim_dispatch_issue | tee /dev/stderr | grep -qx "TEST PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
